/* src/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

  localparam int XLEN  = 64;
  localparam int OPT_W = 4;

  typedef logic [XLEN-1:0] xlen_t;

  // opcode layout is {unsigned, size[1:0], store}.
  typedef enum logic [OPT_W-1:0] {
    LB  = 4'b0000,
    LH  = 4'b0010,
    LW  = 4'b0100,
    LD  = 4'b0110,
    LBU = 4'b1000,
    LHU = 4'b1010,
    LWU = 4'b1100,
    SB  = 4'b0001,
    SH  = 4'b0011,
    SW  = 4'b0101,
    SD  = 4'b0111
  } opt_t;

  // access size as carried in opcode bits 2:1.
  localparam logic [1:0] SZ_BYTE = 2'd0;
  localparam logic [1:0] SZ_HALF = 2'd1;
  localparam logic [1:0] SZ_WORD = 2'd2;
  localparam logic [1:0] SZ_DBL  = 2'd3;

  // One memory word with a byte view and a halfword view.
  typedef union packed {
    logic [7:0][7:0]  lane_b;  // eight byte lanes.
    logic [3:0][15:0] lane_h;  // four halfword lanes.
  } mem_word_u;

endpackage

`default_nettype wire

/* src/bus_pkg.sv */
`default_nettype none

package bus_pkg;

  localparam int ADDR_W = 32;
  localparam int STRB_W = 8;

  localparam int DMEM_BYTES = 1024;           // addresses at or above this are unmapped.
  localparam int DMEM_WORDS = DMEM_BYTES / 8;
  localparam int WIDX_W     = $clog2(DMEM_WORDS);

  localparam int TIMEOUT_CYCLES = 8;          // access cycles before the transfer is dropped.
  localparam int TMR_W          = $clog2(TIMEOUT_CYCLES + 1);

  typedef logic [ADDR_W-1:0] addr_t;

  typedef enum logic [1:0] {
    IDLE   = 2'd0,
    SETUP  = 2'd1,
    ACCESS = 2'd2,
    DONE   = 2'd3
  } apb_state_t;

endpackage

`default_nettype wire

/* src/lsu_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_timer (
  input  logic i_clk,
  input  logic i_rst_n,
  input  logic i_run,    // high while the bus sits in the access phase.
  output logic o_expire
);

  logic [bus_pkg::TMR_W-1:0] cnt_q;

  // the counter stops at the limit so the flag stays up until run drops.
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      cnt_q <= '0;
    end else if (!i_run) begin
      cnt_q <= '0;
    end else if (!o_expire) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign o_expire = (cnt_q == bus_pkg::TMR_W'(bus_pkg::TIMEOUT_CYCLES));

endmodule

`default_nettype wire

/* src/lsu_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_ctrl (
  input  logic i_clk,
  input  logic i_rst_n,
  input  logic i_valid,
  input  logic i_misalign,
  input  logic i_is_store,
  input  logic i_pready,
  input  logic i_expire,
  output logic o_ready,
  output logic o_take,
  output logic o_psel,
  output logic o_penable,
  output logic o_pwrite,
  output logic o_run,
  output logic o_load_done,
  output logic o_done,
  output logic o_err
);

  bus_pkg::apb_state_t state_q, state_d;
  logic                err_q, err_d;

  always_comb begin
    state_d = state_q;
    err_d   = err_q;
    case (state_q)
      bus_pkg::IDLE: begin
        if (i_valid) state_d = bus_pkg::SETUP;
      end
      bus_pkg::SETUP: begin
        state_d = i_misalign ? bus_pkg::DONE : bus_pkg::ACCESS;  // a bad address skips the bus.
        err_d   = i_misalign;
      end
      bus_pkg::ACCESS: begin
        if (i_pready) begin
          state_d = bus_pkg::DONE;
          err_d   = 1'b0;
        end else if (i_expire) begin
          state_d = bus_pkg::DONE;  // nobody answered in time.
          err_d   = 1'b1;
        end
      end
      default: begin
        state_d = bus_pkg::IDLE;
        err_d   = 1'b0;
      end
    endcase
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q <= bus_pkg::IDLE;
      err_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      err_q   <= err_d;
    end
  end

  assign o_ready     = (state_q == bus_pkg::IDLE);
  assign o_take      = o_ready && i_valid;
  assign o_psel      = ((state_q == bus_pkg::SETUP) && !i_misalign) || o_penable;
  assign o_penable   = (state_q == bus_pkg::ACCESS);
  assign o_pwrite    = o_psel && i_is_store;
  assign o_run       = o_penable;
  assign o_load_done = o_penable && i_pready && !i_is_store;  // the read word is on the bus now.
  assign o_done      = (state_q == bus_pkg::DONE);
  assign o_err       = err_q;  // only ever set for the single done cycle.

endmodule

`default_nettype wire

/* src/lsu_datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_datapath (
  input  logic                        i_clk,
  input  logic                        i_rst_n,
  input  logic                        i_take,
  input  lsu_pkg::opt_t               i_opt,
  input  bus_pkg::addr_t              i_addr,
  input  lsu_pkg::xlen_t              i_wdata,
  input  lsu_pkg::mem_word_u          i_prdata,
  input  logic                        i_load_done,
  output logic                        o_misalign,
  output logic                        o_is_store,
  output bus_pkg::addr_t              o_paddr,
  output lsu_pkg::xlen_t              o_pwdata,
  output logic [bus_pkg::STRB_W-1:0]  o_pstrb,
  output lsu_pkg::xlen_t              o_rdata
);

  lsu_pkg::opt_t             opt_q;
  bus_pkg::addr_t            addr_q;
  lsu_pkg::xlen_t            wdata_q;
  lsu_pkg::xlen_t            ld_val;
  logic [1:0]                size;
  logic                      uns;
  logic [bus_pkg::STRB_W-1:0] strb_base;
  logic [7:0]                ld_b;
  logic [15:0]               ld_h;
  logic [31:0]               ld_w;

  always_ff @(posedge i_clk) begin
    if (i_take) begin  // the core only holds its inputs for the accepting cycle.
      opt_q   <= i_opt;
      addr_q  <= i_addr;
      wdata_q <= i_wdata;
    end
  end

  assign size       = opt_q[2:1];
  assign uns        = opt_q[3];
  assign o_is_store = opt_q[0];
  assign o_paddr    = addr_q;

  always_comb begin
    case (size)
      lsu_pkg::SZ_BYTE: begin
        o_misalign = 1'b0;
        strb_base  = 8'h01;
        o_pwdata   = {8{wdata_q[7:0]}};
      end
      lsu_pkg::SZ_HALF: begin
        o_misalign = addr_q[0];
        strb_base  = 8'h03;
        o_pwdata   = {4{wdata_q[15:0]}};
      end
      lsu_pkg::SZ_WORD: begin
        o_misalign = |addr_q[1:0];
        strb_base  = 8'h0f;
        o_pwdata   = {2{wdata_q[31:0]}};
      end
      default: begin
        o_misalign = |addr_q[2:0];
        strb_base  = 8'hff;
        o_pwdata   = wdata_q;
      end
    endcase
  end

  assign o_pstrb = o_is_store ? (strb_base << addr_q[2:0]) : '0;  // loads strobe nothing.

  // lanes come from the union views; a word is two adjacent halfwords.
  assign ld_b = i_prdata.lane_b[addr_q[2:0]];
  assign ld_h = i_prdata.lane_h[addr_q[2:1]];
  assign ld_w = {i_prdata.lane_h[{addr_q[2], 1'b1}], i_prdata.lane_h[{addr_q[2], 1'b0}]};

  always_comb begin
    case (size)
      lsu_pkg::SZ_BYTE: ld_val = {{(lsu_pkg::XLEN-8){ld_b[7] & ~uns}}, ld_b};
      lsu_pkg::SZ_HALF: ld_val = {{(lsu_pkg::XLEN-16){ld_h[15] & ~uns}}, ld_h};
      lsu_pkg::SZ_WORD: ld_val = {{(lsu_pkg::XLEN-32){ld_w[31] & ~uns}}, ld_w};
      default:          ld_val = i_prdata.lane_b;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_rdata <= '0;
    end else if (i_load_done) begin
      o_rdata <= ld_val;  // stores and failed loads keep the last value.
    end
  end

endmodule

`default_nettype wire

/* src/dmem_apb.sv */
`timescale 1ns/1ps
`default_nettype none

module dmem_apb (
  input  logic                        i_clk,
  input  logic                        i_rst_n,
  input  logic                        i_psel,
  input  logic                        i_penable,
  input  logic                        i_pwrite,
  input  bus_pkg::addr_t              i_paddr,
  input  lsu_pkg::xlen_t              i_pwdata,
  input  logic [bus_pkg::STRB_W-1:0]  i_pstrb,
  output lsu_pkg::mem_word_u          o_prdata,
  output logic                        o_pready
);

  lsu_pkg::mem_word_u               mem [bus_pkg::DMEM_WORDS];
  logic [bus_pkg::WIDX_W-1:0]       widx;
  logic                             mapped;
  logic                             setup;

  assign widx   = i_paddr[bus_pkg::WIDX_W+2:3];
  assign mapped = (i_paddr < bus_pkg::ADDR_W'(bus_pkg::DMEM_BYTES));
  assign setup  = i_psel && !i_penable;

  // pready is prepared during setup so it shows in the first access cycle.
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_pready <= 1'b0;
    end else begin
      o_pready <= setup && mapped;  // unmapped addresses never answer.
    end
  end

  always_ff @(posedge i_clk) begin
    if (setup && mapped) begin
      o_prdata <= mem[widx];
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int w = 0; w < bus_pkg::DMEM_WORDS; w++) begin
        mem[w] <= '0;
      end
    end else if (i_psel && i_penable && i_pwrite && o_pready) begin
      for (int i = 0; i < bus_pkg::STRB_W; i++) begin
        if (i_pstrb[i]) begin
          mem[widx].lane_b[i] <= i_pwdata[8*i +: 8];  // untouched lanes keep their bytes.
        end
      end
    end
  end

endmodule

`default_nettype wire

/* src/lsu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_top (
  input  logic           i_clk,
  input  logic           i_rst_n,
  input  logic           i_valid,
  input  lsu_pkg::opt_t  i_opt,
  input  bus_pkg::addr_t i_addr,
  input  lsu_pkg::xlen_t i_wdata,
  output logic           o_ready,
  output logic           o_done,
  output logic           o_err,
  output lsu_pkg::xlen_t o_rdata
);

  logic                        take;
  logic                        misalign;
  logic                        is_store;
  logic                        run;
  logic                        expire;
  logic                        load_done;
  logic                        psel;
  logic                        penable;
  logic                        pwrite;
  logic                        pready;
  bus_pkg::addr_t              paddr;
  lsu_pkg::xlen_t              pwdata;
  logic [bus_pkg::STRB_W-1:0]  pstrb;
  lsu_pkg::mem_word_u          prdata;

  lsu_ctrl u_ctrl (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_valid     (i_valid),
    .i_misalign  (misalign),
    .i_is_store  (is_store),
    .i_pready    (pready),
    .i_expire    (expire),
    .o_ready     (o_ready),
    .o_take      (take),
    .o_psel      (psel),
    .o_penable   (penable),
    .o_pwrite    (pwrite),
    .o_run       (run),
    .o_load_done (load_done),
    .o_done      (o_done),
    .o_err       (o_err)
  );

  lsu_timer u_timer (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_run    (run),
    .o_expire (expire)
  );

  lsu_datapath u_datapath (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_take      (take),
    .i_opt       (i_opt),
    .i_addr      (i_addr),
    .i_wdata     (i_wdata),
    .i_prdata    (prdata),
    .i_load_done (load_done),
    .o_misalign  (misalign),
    .o_is_store  (is_store),
    .o_paddr     (paddr),
    .o_pwdata    (pwdata),
    .o_pstrb     (pstrb),
    .o_rdata     (o_rdata)
  );

  dmem_apb u_dmem (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_psel    (psel),
    .i_penable (penable),
    .i_pwrite  (pwrite),
    .i_paddr   (paddr),
    .i_pwdata  (pwdata),
    .i_pstrb   (pstrb),
    .o_prdata  (prdata),
    .o_pready  (pready)
  );

endmodule

`default_nettype wire

/* test/tb_lsu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_lsu_top;

  localparam int MAX_VEC  = 64;
  localparam int WAIT_MAX = bus_pkg::TIMEOUT_CYCLES + 6;  // longest wait for o_done in cycles.

  logic           i_clk;
  logic           i_rst_n;
  logic           i_valid;
  lsu_pkg::opt_t  i_opt;
  bus_pkg::addr_t i_addr;
  lsu_pkg::xlen_t i_wdata;
  logic           o_ready;
  logic           o_done;
  logic           o_err;
  lsu_pkg::xlen_t o_rdata;

  logic [63:0]    vec_mem [MAX_VEC*5];  // five words per vector.
  logic [7:0]     ref_mem [bus_pkg::DMEM_BYTES];
  lsu_pkg::xlen_t ref_rdata;
  int             n_vec;
  integer         seed;
  int             data_errs;
  int             err_errs;
  int             flag_errs;

  lsu_top DUT (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_valid (i_valid),
    .i_opt   (i_opt),
    .i_addr  (i_addr),
    .i_wdata (i_wdata),
    .o_ready (o_ready),
    .o_done  (o_done),
    .o_err   (o_err),
    .o_rdata (o_rdata)
  );

  always #50 i_clk = ~i_clk;

  task automatic check_data(input lsu_pkg::xlen_t got, input lsu_pkg::xlen_t exp,
                            input string msg);
    if (got !== exp) begin
      data_errs++;
      $display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, msg, got, exp);
    end
  endtask

  task automatic check_err(input logic got, input logic exp, input string msg);
    if (got !== exp) begin
      err_errs++;
      $display("CHECK FAILED at %0t: %s, got %b, expected %b", $time, msg, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string msg);
    if (got !== exp) begin
      flag_errs++;
      $display("CHECK FAILED at %0t: %s, got %b, expected %b", $time, msg, got, exp);
    end
  endtask

  // byte memory model with sign or zero extension of the loaded lane.
  task automatic run_model(input logic [3:0] opt, input logic [31:0] addr,
                           input lsu_pkg::xlen_t wdata, output logic exp_err);
    int             nbytes;
    int             base;
    lsu_pkg::xlen_t val;
    nbytes  = 1 << opt[2:1];
    base    = int'(addr[9:0]);
    val     = '0;
    exp_err = (addr % nbytes != 0) || (addr >= bus_pkg::DMEM_BYTES);
    if (!exp_err) begin
      for (int j = 0; j < nbytes; j++) begin
        if (opt[0]) begin
          ref_mem[base + j] = wdata[8*j +: 8];
        end else begin
          val[8*j +: 8] = ref_mem[base + j];
        end
      end
      if (!opt[0]) begin
        if (!opt[3] && nbytes < 8 && val[8*nbytes-1]) begin
          val = val | ~((64'd1 << (8*nbytes)) - 64'd1);  // fill the upper bits with the sign.
        end
        ref_rdata = val;
      end
    end
  endtask

  task automatic do_request(input int idx);
    logic [3:0] opt;
    logic       exp_err;
    int         gap;
    int         cycles;
    opt = vec_mem[5*idx][3:0];
    gap = $unsigned($random(seed)) % 4;
    repeat (gap) @(negedge i_clk);
    run_model(opt, vec_mem[5*idx+1][31:0], vec_mem[5*idx+2], exp_err);
    check_data(ref_rdata, vec_mem[5*idx+3], $sformatf("golden rdata of vector %0d vs model", idx));
    check_err(exp_err, vec_mem[5*idx+4][0], $sformatf("golden error of vector %0d vs model", idx));
    check_flag(o_ready, 1'b1, $sformatf("o_ready before vector %0d", idx));
    check_flag(o_done, 1'b0, $sformatf("o_done before vector %0d", idx));
    i_valid = 1'b1;
    i_opt   = lsu_pkg::opt_t'(opt);
    i_addr  = vec_mem[5*idx+1][31:0];
    i_wdata = vec_mem[5*idx+2];
    @(negedge i_clk);  // the request was taken at the rising edge in between.
    i_valid = 1'b0;
    cycles  = 0;
    while (!o_done && cycles < WAIT_MAX) begin
      check_flag(o_ready, 1'b0, $sformatf("o_ready while vector %0d is in flight", idx));
      @(negedge i_clk);
      cycles++;
    end
    if (!o_done) begin
      flag_errs++;
      $display("vector %0d got no o_done within %0d cycles of its request", idx, WAIT_MAX);
    end else begin
      check_err(o_err, vec_mem[5*idx+4][0], $sformatf("o_err of vector %0d", idx));
      check_data(o_rdata, vec_mem[5*idx+3], $sformatf("o_rdata of vector %0d", idx));
      @(negedge i_clk);
      check_flag(o_done, 1'b0, $sformatf("o_done one cycle after vector %0d", idx));
      check_flag(o_ready, 1'b1, $sformatf("o_ready after vector %0d", idx));
    end
  endtask

  initial begin
    i_clk     = 1'b0;
    i_rst_n   = 1'b0;
    i_valid   = 1'b0;
    i_opt     = lsu_pkg::LB;
    i_addr    = '0;
    i_wdata   = '0;
    seed      = 66282;
    n_vec     = 0;
    data_errs = 0;
    err_errs  = 0;
    flag_errs = 0;
    ref_rdata = '0;
    for (int i = 0; i < MAX_VEC*5; i++) begin
      vec_mem[i] = {48'hffff_ffff_ffff, 16'(i)};  // end marker in the upper bits.
    end
    for (int b = 0; b < bus_pkg::DMEM_BYTES; b++) begin
      ref_mem[b] = '0;
    end
    $readmemh("test/lsu_golden.txt", vec_mem);
    while (n_vec < MAX_VEC && vec_mem[5*n_vec][63:16] != 48'hffff_ffff_ffff) begin
      n_vec++;
    end
    repeat (16) @(negedge i_clk);
    i_rst_n = 1'b1;
    @(negedge i_clk);
    check_flag(o_ready, 1'b1, "o_ready after reset");
    check_flag(o_done, 1'b0, "o_done after reset");
    check_err(o_err, 1'b0, "o_err after reset");
    check_data(o_rdata, '0, "o_rdata after reset");
    if (n_vec == 0) begin
      flag_errs++;
      $display("no vectors could be read from test/lsu_golden.txt");
    end
    for (int v = 0; v < n_vec; v++) begin
      do_request(v);
    end
    $display("errors: data %0d, error bit %0d, handshake %0d", data_errs, err_errs, flag_errs);
    if (data_errs + err_errs + flag_errs == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    @(posedge i_rst_n);  // the vector count is final long before reset is released.
    #((n_vec * WAIT_MAX + 40) * 100);
    $display("watchdog expired before all vectors were run");
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* test/lsu_golden.txt */
// columns: opcode, address, store data, expected rdata, expected error; all hex.
// opcodes: LB 0, LH 2, LW 4, LD 6, LBU 8, LHU a, LWU c, SB 1, SH 3, SW 5, SD 7.
7 00000010 8899aabbccddeeff 0000000000000000 0
6 00000010 0000000000000000 8899aabbccddeeff 0
0 00000010 0000000000000000 ffffffffffffffff 0
0 00000013 0000000000000000 ffffffffffffffcc 0
8 00000017 0000000000000000 0000000000000088 0
2 00000012 0000000000000000 ffffffffffffccdd 0
a 00000016 0000000000000000 0000000000008899 0
4 00000014 0000000000000000 ffffffff8899aabb 0
c 00000010 0000000000000000 00000000ccddeeff 0
7 00000020 7f6e5d4c3b2a1908 00000000ccddeeff 0
4 00000024 0000000000000000 000000007f6e5d4c 0
2 00000020 0000000000000000 0000000000001908 0
0 00000021 0000000000000000 0000000000000019 0
1 00000011 00000000000000a5 0000000000000019 0
3 00000014 0000000000001234 0000000000000019 0
5 00000020 00000000deadbeef 0000000000000019 0
6 00000010 0000000000000000 88991234ccdda5ff 0
6 00000020 0000000000000000 7f6e5d4cdeadbeef 0
3 00000011 ffffffffffffffff 7f6e5d4cdeadbeef 1
5 00000022 ffffffffffffffff 7f6e5d4cdeadbeef 1
7 00000014 ffffffffffffffff 7f6e5d4cdeadbeef 1
2 00000013 0000000000000000 7f6e5d4cdeadbeef 1
4 00000016 0000000000000000 7f6e5d4cdeadbeef 1
6 0000001c 0000000000000000 7f6e5d4cdeadbeef 1
6 00000010 0000000000000000 88991234ccdda5ff 0
6 00000400 0000000000000000 88991234ccdda5ff 1
1 00000500 000000000000005a 88991234ccdda5ff 1
7 000003f8 0123456789abcdef 88991234ccdda5ff 0
8 000003ff 0000000000000000 0000000000000001 0
5 00001000 0000000011111111 0000000000000001 1
2 000003fa 0000000000000000 ffffffffffff89ab 0
8 00000100 0000000000000000 0000000000000000 0

/* lsu_top.f */
src/lsu_pkg.sv
src/bus_pkg.sv
src/lsu_timer.sv
src/lsu_ctrl.sv
src/lsu_datapath.sv
src/dmem_apb.sv
src/lsu_top.sv
test/tb_lsu_top.sv

/* run.sh */
#!/usr/bin/env bash
# Compile with Verilator, run, and judge the result from the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -j 0 --top-module tb_lsu_top -f lsu_top.f > sim.log 2>&1 \
  && ./obj_dir/Vtb_lsu_top >> sim.log 2>&1 \
  || { echo "build or simulation did not complete" >> sim.log; cat sim.log; exit 1; }
cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && exit 1
grep -q "TEST RESULT: PASS" sim.log || exit 1
exit 0
